/* hw/secp_endo_pkg.sv */
//====================
// secp256k1 GLV decomposition constants
// curve, lattice basis and multiplier command codes
//====================
`default_nettype none

package secp_endo_pkg;

  // field prime p = 2^256 - 2^32 - 977
  localparam logic [255:0] P_MOD =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_FFFFFC2F;

  // cube root of unity mod p, x -> beta*x
  localparam logic [255:0] BETA =
    256'h7AE96A2B_657C0710_6E64479E_AC3434E9_9CF04975_12F58995_C1396C28_719501EE;

  // matching scalar root mod n, checked only outside the datapath
  localparam logic [255:0] LAMBDA =
    256'h5363AD4C_C05C30E0_A5261C02_8812645A_122E22EA_20816678_DF02967C_1B23BD72;

  // lattice basis, b1 kept as its negation
  localparam logic [255:0] A1     = 256'h3086D221_A7D46BCD_E86C90E4_9284EB15;
  localparam logic [255:0] B1_NEG = 256'hE4437ED6_010E8828_6F547FA9_0ABFE4C3;
  localparam logic [255:0] A2     = 256'h1_14CA50F7_A8E2F3F6_57C1108D_9D44CFD8;
  localparam logic [255:0] B2     = 256'h3086D221_A7D46BCD_E86C90E4_9284EB15;

  // round(2^384 * b / n) style multipliers for c1 and c2
  localparam logic [255:0] C1_PRE =
    256'h3086D221_A7D46BCD_E86C90E4_9284EB15_3DAA8A14_71E8CA7F_E893209A_45DBB031;
  localparam logic [255:0] C2_PRE =
    256'hE4437ED6_010E8828_6F547FA9_0ABFE4C4_221208AC_9DF506C6_1571B4AE_8AC47F71;

  // multiplier commands
  localparam logic CMD_MODP  = 1'b0;  // a*b mod p
  localparam logic CMD_SCALE = 1'b1;  // (a*b + 2^383) >> 384

  localparam int TAG_W       = 3;    // tags 0..6
  localparam int SCALE_SHIFT = 384;
  localparam int N_MULTS     = 7;    // multiplies per request

endpackage

`default_nettype wire

/* hw/endo_req_buffer.sv */
//====================
// request buffer
// one entry holding point and scalar for the scheduler
//====================
`timescale 1ns/100ps
`default_nettype none

module endo_req_buffer (
  input  logic         i_clk,
  input  logic         i_rst,
  input  logic         i_val,
  output logic         o_rdy,
  input  logic [255:0] i_px,
  input  logic [255:0] i_py,
  input  logic [255:0] i_pz,
  input  logic [255:0] i_k,
  output logic         o_req_val,
  input  logic         i_req_take,
  output logic [255:0] o_req_px,
  output logic [255:0] o_req_py,
  output logic [255:0] o_req_pz,
  output logic [255:0] o_req_k
);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_req_val <= 1'b0;
      o_rdy     <= 1'b0;       // rises one cycle after reset drops
    end else if (i_val && o_rdy) begin
      o_req_val <= 1'b1;       // offered to scheduler next cycle
      o_rdy     <= 1'b0;
    end else if (i_req_take) begin
      o_req_val <= 1'b0;
      o_rdy     <= 1'b1;       // free again
    end else begin
      o_rdy     <= !o_req_val;
    end
  end

  // payload, loaded on accept only
  always_ff @(posedge i_clk) begin
    if (i_val && o_rdy) begin
      o_req_px <= i_px;
      o_req_py <= i_py;
      o_req_pz <= i_pz;
      o_req_k  <= i_k;
    end
  end

  // scheduler may only take a request that is actually held
  a_take_full: assert property (@(posedge i_clk) disable iff (i_rst)
    i_req_take |-> o_req_val)
    else $error("request taken from empty buffer");

endmodule

`default_nettype wire

/* hw/field_mult_serial.sv */
//====================
// serial 256x256 multiplier
// msb-first, one bit of b per cycle, mod-p or scaled result
//====================
`timescale 1ns/100ps
`default_nettype none

module field_mult_serial
  import secp_endo_pkg::*;
(
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_req_val,
  output logic             o_req_rdy,
  input  logic [255:0]     i_a,
  input  logic [255:0]     i_b,
  input  logic             i_cmd,
  input  logic [TAG_W-1:0] i_tag,
  output logic             o_res_val,
  input  logic             i_res_rdy,
  output logic [255:0]     o_res,
  output logic [TAG_W-1:0] o_res_tag
);

  logic         busy;
  logic [7:0]   bit_cnt;
  logic [255:0] a_q, b_sh;
  logic         cmd_q;
  logic [511:0] acc, acc_nxt;   // low half only in mod-p mode
  logic [255:0] addend;
  logic [256:0] dbl, dbl_red, sum, sum_red;
  logic [511:0] acc_sh;
  logic [255:0] scaled;

  assign o_req_rdy = !busy && !o_res_val;  // one op in flight

  always_comb begin
    addend  = b_sh[255] ? a_q : '0;
    // mod p by double, reduce, add and reduce again
    dbl     = {acc[255:0], 1'b0};
    dbl_red = (dbl >= {1'b0, P_MOD}) ? dbl - {1'b0, P_MOD} : dbl;
    sum     = {1'b0, dbl_red[255:0]} + {1'b0, addend};
    sum_red = (sum >= {1'b0, P_MOD}) ? sum - {1'b0, P_MOD} : sum;
    // plain shift-and-add for scale
    acc_sh  = {acc[510:0], 1'b0} + {256'd0, addend};
    acc_nxt = (cmd_q == CMD_MODP) ? {256'd0, sum_red[255:0]} : acc_sh;
    // round on the bit just below the shift point
    scaled  = 256'(acc_nxt[511:SCALE_SHIFT]) + 256'(acc_nxt[SCALE_SHIFT-1]);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy      <= 1'b0;
      o_res_val <= 1'b0;
      bit_cnt   <= '0;
    end else begin
      if (i_req_val && o_req_rdy) begin
        busy      <= 1'b1;
        bit_cnt   <= '0;
      end else if (busy) begin
        bit_cnt <= bit_cnt + 8'd1;
        if (bit_cnt == 8'd255) begin  // last bit lands 256 edges after accept
          busy      <= 1'b0;
          o_res_val <= 1'b1;
        end
      end
      if (o_res_val && i_res_rdy) o_res_val <= 1'b0;
    end
  end

  // operands and datapath
  always_ff @(posedge i_clk) begin
    if (i_req_val && o_req_rdy) begin
      a_q       <= i_a;
      b_sh      <= i_b;
      cmd_q     <= i_cmd;
      o_res_tag <= i_tag;
      acc       <= '0;
    end else if (busy) begin
      acc  <= acc_nxt;
      b_sh <= {b_sh[254:0], 1'b0};  // next bit of b to the top
      if (bit_cnt == 8'd255) o_res <= (cmd_q == CMD_SCALE) ? scaled : acc_nxt[255:0];
    end
  end

  // valid rises on edge 256 after accept, so it is first sampled high one tick later
  a_latency: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_req_val && o_req_rdy) |-> ##257 o_res_val)
    else $error("multiplier latency is not 256 cycles");

  a_res_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_res_val && !i_res_rdy) |=> (o_res_val && $stable(o_res) && $stable(o_res_tag)))
    else $error("multiplier result changed while waiting");

endmodule

`default_nettype wire

/* hw/endo_decom_sched.sv */
//====================
// decomposition scheduler
// issues the seven tagged multiplies, collects results by tag
// and does the k1/k2 subtractions in place
//====================
`timescale 1ns/100ps
`default_nettype none

module endo_decom_sched
  import secp_endo_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_req_val,
  output logic                o_req_take,
  input  logic [255:0]        i_px,
  input  logic [255:0]        i_py,
  input  logic [255:0]        i_pz,
  input  logic [255:0]        i_k,
  output logic                o_mul_val,
  input  logic                i_mul_rdy,
  output logic [255:0]        o_mul_a,
  output logic [255:0]        o_mul_b,
  output logic                o_mul_cmd,
  output logic [TAG_W-1:0]    o_mul_tag,
  input  logic                i_mul_res_val,
  output logic                o_mul_res_rdy,
  input  logic [255:0]        i_mul_res,
  input  logic [TAG_W-1:0]    i_mul_res_tag,
  output logic                o_res_val,
  input  logic                i_res_rdy,
  output logic [255:0]        o_res_px,
  output logic [255:0]        o_res_py,
  output logic [255:0]        o_res_pz,
  output logic signed [255:0] o_res_k1,
  output logic signed [255:0] o_res_k2
);

  // bits 0..6 are multiplies, 7..9 are the local subtractions
  //   7: k1 = k - c1a1   8: k1 -= c2a2   9: k2 = c1b1 - c2b2
  enum logic [1:0] {ST_IDLE, ST_RUN, ST_DONE} state;

  logic [N_MULTS-1:0] issued;
  logic [9:0]         done;
  logic [255:0]       c1, c2, c1_a1, c2_a2, c2_b2;

  logic               iss_en;
  logic [TAG_W-1:0]   iss_tag;
  logic [255:0]       iss_a, iss_b;
  logic               iss_cmd;

  assign o_req_take    = (state == ST_IDLE) && i_req_val;
  assign o_mul_res_rdy = (state == ST_RUN);  // results taken the cycle they show up

  // pick next multiply whose inputs are ready, fixed priority
  always_comb begin
    iss_en  = 1'b1;
    iss_tag = TAG_W'(0);
    iss_a   = o_res_px;          // addend stays below p in mod-p mode
    iss_b   = BETA;
    iss_cmd = CMD_MODP;
    if (!issued[0]) begin
      iss_tag = TAG_W'(0);       // beta*x
    end else if (!issued[1]) begin
      iss_tag = TAG_W'(1);       // c1, k still in k1 reg
      iss_a   = o_res_k1;
      iss_b   = C1_PRE;
      iss_cmd = CMD_SCALE;
    end else if (!issued[2]) begin
      iss_tag = TAG_W'(2);
      iss_a   = o_res_k1;
      iss_b   = C2_PRE;
      iss_cmd = CMD_SCALE;
    end else if (!issued[3] && done[1]) begin
      iss_tag = TAG_W'(3);       // c1*a1
      iss_a   = c1;
      iss_b   = A1;
    end else if (!issued[4] && done[2]) begin
      iss_tag = TAG_W'(4);       // c2*a2
      iss_a   = c2;
      iss_b   = A2;
    end else if (!issued[5] && done[1]) begin
      iss_tag = TAG_W'(5);       // c1*b1_neg, lands in k2
      iss_a   = c1;
      iss_b   = B1_NEG;
    end else if (!issued[6] && done[2]) begin
      iss_tag = TAG_W'(6);       // c2*b2
      iss_a   = c2;
      iss_b   = B2;
    end else begin
      iss_en  = 1'b0;            // nothing issuable yet
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= ST_IDLE;
      o_mul_val <= 1'b0;
      o_res_val <= 1'b0;
      issued    <= '0;
      done      <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_req_val) begin
            state    <= ST_RUN;
            o_res_px <= i_px;    // replaced by beta*x later
            o_res_py <= i_py;
            o_res_pz <= i_pz;
            o_res_k1 <= i_k;
            o_res_k2 <= '0;
            issued   <= '0;
            done     <= '0;
          end
        end
        ST_RUN: begin
          if (o_mul_val && i_mul_rdy) o_mul_val <= 1'b0;
          if (iss_en && (!o_mul_val || i_mul_rdy)) begin
            o_mul_val        <= 1'b1;
            o_mul_a          <= iss_a;
            o_mul_b          <= iss_b;
            o_mul_cmd        <= iss_cmd;
            o_mul_tag        <= iss_tag;
            issued[iss_tag]  <= 1'b1;
          end
          // store result by tag
          if (i_mul_res_val) begin
            done[i_mul_res_tag] <= 1'b1;
            case (i_mul_res_tag)
              TAG_W'(0): o_res_px <= i_mul_res;
              TAG_W'(1): c1       <= i_mul_res;
              TAG_W'(2): c2       <= i_mul_res;
              TAG_W'(3): c1_a1    <= i_mul_res;
              TAG_W'(4): c2_a2    <= i_mul_res;
              TAG_W'(5): o_res_k2 <= i_mul_res;
              default:   c2_b2    <= i_mul_res;
            endcase
          end
          if (done[3] && !done[7]) begin
            o_res_k1 <= o_res_k1 - $signed(c1_a1);
            done[7]  <= 1'b1;
          end
          if (done[7] && done[4] && !done[8]) begin  // second half of k1
            o_res_k1 <= o_res_k1 - $signed(c2_a2);
            done[8]  <= 1'b1;
          end
          if (done[5] && done[6] && !done[9]) begin
            o_res_k2 <= o_res_k2 - $signed(c2_b2);
            done[9]  <= 1'b1;
          end
          if (&done) begin
            state     <= ST_DONE;
            o_res_val <= 1'b1;
          end
        end
        default: begin
          // hold here until the output buffer has room
          if (i_res_rdy) begin
            state     <= ST_IDLE;
            o_res_val <= 1'b0;
          end
        end
      endcase
    end
  end

  // multiplier only ever hands back tags that were issued
  a_tag_range: assert property (@(posedge i_clk) disable iff (i_rst)
    i_mul_res_val |-> (i_mul_res_tag < TAG_W'(N_MULTS)))
    else $error("multiplier returned tag out of range");

endmodule

`default_nettype wire

/* hw/endo_result_buffer.sv */
//====================
// result buffer
// one entry for point and k1/k2, valid/ready to the consumer
//====================
`timescale 1ns/100ps
`default_nettype none

module endo_result_buffer (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_val,
  output logic                o_rdy,
  input  logic [255:0]        i_px,
  input  logic [255:0]        i_py,
  input  logic [255:0]        i_pz,
  input  logic signed [255:0] i_k1,
  input  logic signed [255:0] i_k2,
  output logic                o_val,
  input  logic                i_rdy,
  output logic [255:0]        o_px,
  output logic [255:0]        o_py,
  output logic [255:0]        o_pz,
  output logic signed [255:0] o_k1,
  output logic signed [255:0] o_k2
);

  assign o_rdy = !o_val;  // takes a result only when empty

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else if (i_val && o_rdy) begin
      o_val <= 1'b1;
    end else if (o_val && i_rdy) begin
      o_val <= 1'b0;       // consumer took it
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_val && o_rdy) begin
      o_px <= i_px;
      o_py <= i_py;
      o_pz <= i_pz;
      o_k1 <= i_k1;
      o_k2 <= i_k2;
    end
  end

  // stalled output must not move
  a_out_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_val && !i_rdy) |=> (o_val && $stable(o_px) && $stable(o_py) && $stable(o_pz)
                           && $stable(o_k1) && $stable(o_k2)))
    else $error("output changed under back-pressure");

endmodule

`default_nettype wire

/* hw/endo_decom_top.sv */
//====================
// GLV decomposition top
// request buffer, scheduler, shared multiplier, result buffer
//====================
`timescale 1ns/100ps
`default_nettype none

module endo_decom_top
  import secp_endo_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_val,
  output logic                o_rdy,
  input  logic [255:0]        i_px,
  input  logic [255:0]        i_py,
  input  logic [255:0]        i_pz,
  input  logic [255:0]        i_k,
  output logic                o_val,
  input  logic                i_rdy,
  output logic [255:0]        o_px,
  output logic [255:0]        o_py,
  output logic [255:0]        o_pz,
  output logic signed [255:0] o_k1,
  output logic signed [255:0] o_k2
);

  logic                req_val, req_take;
  logic [255:0]        req_px, req_py, req_pz, req_k;
  logic                mul_req_val, mul_req_rdy, mul_cmd;
  logic [255:0]        mul_a, mul_b, mul_res;
  logic [TAG_W-1:0]    mul_tag, mul_res_tag;
  logic                mul_res_val, mul_res_rdy;
  logic                res_val, res_rdy;
  logic [255:0]        res_px, res_py, res_pz;
  logic signed [255:0] res_k1, res_k2;

  endo_req_buffer u_req (
    .i_clk, .i_rst, .i_val, .o_rdy, .i_px, .i_py, .i_pz, .i_k,
    .o_req_val (req_val), .i_req_take (req_take),
    .o_req_px (req_px), .o_req_py (req_py), .o_req_pz (req_pz), .o_req_k (req_k)
  );

  endo_decom_sched u_sched (
    .i_clk, .i_rst,
    .i_req_val (req_val), .o_req_take (req_take),
    .i_px (req_px), .i_py (req_py), .i_pz (req_pz), .i_k (req_k),
    .o_mul_val (mul_req_val), .i_mul_rdy (mul_req_rdy), .o_mul_a (mul_a), .o_mul_b (mul_b),
    .o_mul_cmd (mul_cmd), .o_mul_tag (mul_tag),
    .i_mul_res_val (mul_res_val), .o_mul_res_rdy (mul_res_rdy),
    .i_mul_res (mul_res), .i_mul_res_tag (mul_res_tag),
    .o_res_val (res_val), .i_res_rdy (res_rdy),
    .o_res_px (res_px), .o_res_py (res_py), .o_res_pz (res_pz),
    .o_res_k1 (res_k1), .o_res_k2 (res_k2)
  );

  field_mult_serial u_mult (
    .i_clk, .i_rst,
    .i_req_val (mul_req_val), .o_req_rdy (mul_req_rdy),
    .i_a (mul_a), .i_b (mul_b), .i_cmd (mul_cmd), .i_tag (mul_tag),
    .o_res_val (mul_res_val), .i_res_rdy (mul_res_rdy),
    .o_res (mul_res), .o_res_tag (mul_res_tag)
  );

  endo_result_buffer u_res (
    .i_clk, .i_rst,
    .i_val (res_val), .o_rdy (res_rdy),
    .i_px (res_px), .i_py (res_py), .i_pz (res_pz), .i_k1 (res_k1), .i_k2 (res_k2),
    .o_val, .i_rdy, .o_px, .o_py, .o_pz, .o_k1, .o_k2
  );

endmodule

`default_nettype wire

/* tb/tb_endo_decom.sv */
//====================
// GLV decomposition testbench
// reference model, queued expectations, stall checks on the output
//====================
`timescale 1ns/100ps
`default_nettype none

module tb_endo_decom
  import secp_endo_pkg::*;
();

  localparam int          TIMEOUT   = 5000;          // cycles per request
  localparam int          N_RANDOM  = 20;
  localparam logic [31:0] SEED      = 32'h8a32;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;  // x^32+x^22+x^2+x+1
  // generator point of the curve, used as the known point
  localparam logic [255:0] GX =
    256'h79BE667E_F9DCBBAC_55A06295_CE870B07_029BFCDB_2DCE28D9_59F2815B_16F81798;
  localparam logic [255:0] GY =
    256'h483ADA77_26A3C465_5DA4FBFC_0E1108A8_FD17B448_A6855419_9C47D08F_FB10D4B8;

  logic                i_clk, i_rst, i_val, o_rdy, o_val, i_rdy;
  logic [255:0]        i_px, i_py, i_pz, i_k, o_px, o_py, o_pz;
  logic signed [255:0] o_k1, o_k2;

  logic [31:0]         stim_lfsr, bp_lfsr;  // separate streams for data and stalls
  logic [255:0]        bp_bits;
  logic                bp_en, hold_q;
  int                  bp_left, sent_count, rcv_count;
  logic [255:0]        held_px, held_py, held_pz;
  logic signed [255:0] held_k1, held_k2;

  // expected results in request order
  string               exp_name[$];
  logic [255:0]        exp_px[$], exp_py[$], exp_pz[$];
  logic signed [255:0] exp_k1[$], exp_k2[$];

  endo_decom_top uut (
    .i_clk, .i_rst, .i_val, .o_rdy, .i_px, .i_py, .i_pz, .i_k,
    .o_val, .i_rdy, .o_px, .o_py, .o_pz, .o_k1, .o_k2
  );

  always #4 i_clk = ~i_clk;  // 8 ns period

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic draw_bits(inout logic [31:0] st, input int n, output logic [255:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      st = lfsr_step(st);          // one step per bit
      v  = {v[254:0], st[0]};
    end
  endtask

  task automatic random_coord(output logic [255:0] v);
    draw_bits(stim_lfsr, 256, v);
    if (v >= P_MOD) v = v - P_MOD;   // below 2^256 < 2p, one subtraction is enough
  endtask

  // a*b mod p, straight wide arithmetic
  function automatic logic [255:0] mul_mod_p(input logic [255:0] a, b);
    logic [511:0] prod;
    prod = {256'd0, a} * {256'd0, b};
    return 256'(prod % {256'd0, P_MOD});
  endfunction

  // (a*b + 2^383) >> 384, one spare bit for the rounding carry
  function automatic logic [255:0] mul_scaled(input logic [255:0] a, b);
    logic [512:0] prod;
    prod = ({257'd0, a} * {257'd0, b}) + (513'd1 << (SCALE_SHIFT - 1));
    return 256'(prod >> SCALE_SHIFT);
  endfunction

  function automatic void decompose_ref(input logic [255:0] px, k,
      output logic [255:0] xp, output logic signed [255:0] k1, k2);
    logic [255:0] c1, c2;
    c1 = mul_scaled(k, C1_PRE);
    c2 = mul_scaled(k, C2_PRE);
    k1 = k - mul_mod_p(c1, A1) - mul_mod_p(c2, A2);  // wraps to 256 bits
    k2 = mul_mod_p(c1, B1_NEG) - mul_mod_p(c2, B2);
    xp = mul_mod_p(px, BETA);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping on first error");
  endtask

  task automatic check_coord(input string what, input logic [255:0] exp, act);
    if (exp !== act)
      abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", what, exp, act));
  endtask

  task automatic check_scalar(input string what, input logic signed [255:0] exp, act);
    if (exp !== act)
      abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", what, exp, act));
  endtask

  // offer one request, queue its expectation at the transfer
  task automatic send_req(input string name, input logic [255:0] px, py, pz, k);
    int                  n;
    logic [255:0]        xp;
    logic signed [255:0] k1, k2;
    decompose_ref(px, k, xp, k1, k2);
    i_val = 1'b1;
    i_px  = px;
    i_py  = py;
    i_pz  = pz;
    i_k   = k;
    n     = 0;
    while (!o_rdy) begin
      @(posedge i_clk);
      #1;
      n++;
      if (n > TIMEOUT) abort_run($sformatf("%s was never accepted", name));
    end
    exp_name.push_back(name);
    exp_px.push_back(xp);
    exp_py.push_back(py);   // y and z pass through untouched
    exp_pz.push_back(pz);
    exp_k1.push_back(k1);
    exp_k2.push_back(k2);
    sent_count++;
    @(posedge i_clk);       // transfer edge
    #1;
    i_val = 1'b0;
  endtask

  task automatic wait_drain();
    int n, last;
    n    = 0;
    last = rcv_count;
    while (rcv_count != sent_count) begin
      @(posedge i_clk);
      #1;
      if (rcv_count != last) begin
        n    = 0;             // progress, restart the per-request timeout
        last = rcv_count;
      end else begin
        n++;
      end
      if (n > TIMEOUT) abort_run("timed out waiting for a result on o_val");
    end
  endtask

  // output stalls in LFSR-chosen stretches
  always @(posedge i_clk) begin
    #1;
    if (bp_en) begin
      if (bp_left == 0) begin
        draw_bits(bp_lfsr, 4, bp_bits);
        bp_left = int'(bp_bits[3:0]);
        draw_bits(bp_lfsr, 1, bp_bits);
        i_rdy   = bp_bits[0];
      end else begin
        bp_left--;
      end
    end
  end

  // monitor, values seen here are the ones before the edge
  always @(posedge i_clk) begin
    if (!i_rst) begin
      if (hold_q) begin
        if (!o_val) abort_run("o_val dropped while i_rdy was low");
        check_coord("stall px", held_px, o_px);
        check_coord("stall py", held_py, o_py);
        check_coord("stall pz", held_pz, o_pz);
        check_scalar("stall k1", held_k1, o_k1);
        check_scalar("stall k2", held_k2, o_k2);
      end
      if (o_val && i_rdy) begin
        if (exp_name.size() == 0) abort_run("result delivered with no request pending");
        check_coord($sformatf("%s px", exp_name[0]), exp_px.pop_front(), o_px);
        check_coord($sformatf("%s py", exp_name[0]), exp_py.pop_front(), o_py);
        check_coord($sformatf("%s pz", exp_name[0]), exp_pz.pop_front(), o_pz);
        check_scalar($sformatf("%s k1", exp_name[0]), exp_k1.pop_front(), o_k1);
        check_scalar($sformatf("%s k2", exp_name[0]), exp_k2.pop_front(), o_k2);
        void'(exp_name.pop_front());
        rcv_count++;
      end
      hold_q  = o_val && !i_rdy;
      held_px = o_px;
      held_py = o_py;
      held_pz = o_pz;
      held_k1 = o_k1;
      held_k2 = o_k2;
    end
  end

  initial begin
    int           n;
    logic [255:0] px, py, pz, k;
    i_clk      = 1'b0;
    i_rst      = 1'b1;
    i_val      = 1'b0;
    i_rdy      = 1'b1;
    i_px       = '0;
    i_py       = '0;
    i_pz       = '0;
    i_k        = '0;
    bp_en      = 1'b0;
    bp_left    = 0;
    hold_q     = 1'b0;
    sent_count = 0;
    rcv_count  = 0;
    stim_lfsr  = SEED;
    bp_lfsr    = SEED;
    repeat (4) @(posedge i_clk);
    #1;
    i_rst = 1'b0;

    // o_rdy comes up shortly after reset, nothing on the output
    n = 0;
    while (!o_rdy) begin
      if (o_val) abort_run("o_val high right after reset");
      @(posedge i_clk);
      #1;
      n++;
      if (n > 10) abort_run("o_rdy did not rise after reset");
    end

    send_req("fixed k=0", GX, GY, 256'd1, 256'd0);
    wait_drain();
    send_req("fixed k=1", GX, GY, 256'd1, 256'd1);
    wait_drain();
    send_req("fixed k=2^255+3", GX, GY, 256'd1, (256'd1 << 255) + 256'd3);
    wait_drain();

    // back to back, second half with output stalls
    for (int i = 0; i < N_RANDOM; i++) begin
      if (i == N_RANDOM / 2) bp_en = 1'b1;
      random_coord(px);
      random_coord(py);
      random_coord(pz);
      draw_bits(stim_lfsr, 256, k);
      send_req($sformatf("random %0d", i), px, py, pz, k);
    end
    wait_drain();

    if (rcv_count == sent_count && exp_name.size() == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("results lost: %0d sent, %0d received", sent_count, rcv_count);
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
hw/secp_endo_pkg.sv
hw/endo_req_buffer.sv
hw/field_mult_serial.sv
hw/endo_decom_sched.sv
hw/endo_result_buffer.sv
hw/endo_decom_top.sv
tb/tb_endo_decom.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 --timescale 1ns/100ps
TOP       ?= tb_endo_decom
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
